//--- hdl/decodePkg.sv
package decodePkg;

    localparam int xlen = 32;
    localparam int pcWidth = 31;
    localparam int regAddrWidth = 5;

    // low two opcode bits of every 32-bit instruction
    localparam logic [1:0] quadrant32 = 2'b11;

    typedef logic [xlen-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // major opcodes, quadrant bits included
    typedef enum logic [6:0] {
        opcLui    = 7'b0110111,
        opcAuipc  = 7'b0010111,
        opcJal    = 7'b1101111,
        opcJalr   = 7'b1100111,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011,
        opcRegImm = 7'b0010011,
        opcRegReg = 7'b0110011,
        opcEnv    = 7'b1110011
    } majorOp_e;

    typedef enum logic [1:0] {
        fuInt = 2'd0,
        fuLsu = 2'd1,
        fuMul = 2'd2,
        fuDiv = 2'd3
    } funcUnit_e;

    // one code per micro-op across all units
    typedef enum logic [5:0] {
        intAdd,
        intSub,
        intSll,
        intSlt,
        intSltu,
        intXor,
        intSrl,
        intSra,
        intOr,
        intAnd,
        intLui,
        intAuipc,
        intJal,
        intJalr,
        intSys,
        intBeq,
        intBne,
        intBlt,
        intBge,
        intBltu,
        intBgeu,
        lsuLb,
        lsuLh,
        lsuLw,
        lsuLbu,
        lsuLhu,
        lsuSb,
        lsuSh,
        lsuSw,
        mulMul,
        mulMulh,
        mulMulsu,
        mulMulu,
        divDiv,
        divDivu,
        divRem,
        divRemu,
        intUndefined = 6'h3f
    } uopOpcode_e;

    typedef enum logic [2:0] {
        immNone,
        immI,
        immS,
        immU,
        immJal,
        immBranch
    } immFormat_e;

endpackage

//--- hdl/immGen.sv
`timescale 1ns/1ps

module immGen (
    input  decodePkg::word_t      instr,
    input  decodePkg::immFormat_e immFmt,
    input  decodePkg::word_t      pcByte,
    output decodePkg::word_t      imm
);

    decodePkg::word_t immIType;
    decodePkg::word_t immSType;
    decodePkg::word_t immUType;
    decodePkg::word_t jalOffset;
    decodePkg::word_t branchOffset;

    assign immIType = {{20{instr[31]}}, instr[31:20]};
    assign immSType = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immUType = {instr[31:12], 12'b0};

    // scrambled offsets, always even
    assign jalOffset = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign branchOffset = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (immFmt)
            decodePkg::immI: imm = immIType;
            decodePkg::immS: imm = immSType;
            decodePkg::immU: imm = immUType;
            // pc-relative formats hand out the target itself
            decodePkg::immJal: imm = pcByte + jalOffset;
            decodePkg::immBranch: imm = pcByte + branchOffset;
            default: imm = '0;
        endcase
    end

endmodule

//--- hdl/intOpDecode.sv
`timescale 1ns/1ps

module intOpDecode (
    input  decodePkg::word_t      instr,
    output decodePkg::uopOpcode_e regImmOp,
    output logic                  regImmIllegal,
    output decodePkg::uopOpcode_e regRegOp,
    output decodePkg::funcUnit_e  regRegFu,
    output logic                  regRegIllegal,
    output decodePkg::uopOpcode_e branchOp,
    output logic                  branchIllegal
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register-immediate view
    always_comb begin
        regImmIllegal = (funct3 == 3'd1 && funct7 != 7'h00) ||
                        (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
        case (funct3)
            3'd0: regImmOp = decodePkg::intAdd;
            3'd1: regImmOp = decodePkg::intSll;
            3'd2: regImmOp = decodePkg::intSlt;
            3'd3: regImmOp = decodePkg::intSltu;
            3'd4: regImmOp = decodePkg::intXor;
            3'd5: regImmOp = (funct7 == 7'h20) ? decodePkg::intSra : decodePkg::intSrl;
            3'd6: regImmOp = decodePkg::intOr;
            default: regImmOp = decodePkg::intAnd;
        endcase
    end

    // register-register view, M extension included
    always_comb begin
        regRegOp = decodePkg::intUndefined;
        regRegFu = decodePkg::fuInt;
        regRegIllegal = 1'b1;
        if (funct7 == 7'h00) begin
            regRegIllegal = 1'b0;
            case (funct3)
                3'd0: regRegOp = decodePkg::intAdd;
                3'd1: regRegOp = decodePkg::intSll;
                3'd2: regRegOp = decodePkg::intSlt;
                3'd3: regRegOp = decodePkg::intSltu;
                3'd4: regRegOp = decodePkg::intXor;
                3'd5: regRegOp = decodePkg::intSrl;
                3'd6: regRegOp = decodePkg::intOr;
                default: regRegOp = decodePkg::intAnd;
            endcase
        end else if (funct7 == 7'h01) begin
            regRegIllegal = 1'b0;
            regRegFu = (funct3 < 3'd4) ? decodePkg::fuMul : decodePkg::fuDiv;
            case (funct3)
                3'd0: regRegOp = decodePkg::mulMul;
                3'd1: regRegOp = decodePkg::mulMulh;
                3'd2: regRegOp = decodePkg::mulMulsu;
                3'd3: regRegOp = decodePkg::mulMulu;
                3'd4: regRegOp = decodePkg::divDiv;
                3'd5: regRegOp = decodePkg::divDivu;
                3'd6: regRegOp = decodePkg::divRem;
                default: regRegOp = decodePkg::divRemu;
            endcase
        end else if (funct7 == 7'h20) begin
            regRegIllegal = (funct3 != 3'd0) && (funct3 != 3'd5);
            regRegOp = (funct3 == 3'd0) ? decodePkg::intSub : decodePkg::intSra;
        end
    end

    // branch view
    always_comb begin
        branchIllegal = 1'b0;
        case (funct3)
            3'd0: branchOp = decodePkg::intBeq;
            3'd1: branchOp = decodePkg::intBne;
            3'd4: branchOp = decodePkg::intBlt;
            3'd5: branchOp = decodePkg::intBge;
            3'd6: branchOp = decodePkg::intBltu;
            3'd7: branchOp = decodePkg::intBgeu;
            default: begin
                branchOp = decodePkg::intUndefined;
                branchIllegal = 1'b1;
            end
        endcase
    end

endmodule

//--- hdl/memOpDecode.sv
`timescale 1ns/1ps

module memOpDecode (
    input  decodePkg::word_t      instr,
    output decodePkg::uopOpcode_e loadOp,
    output logic                  loadIllegal,
    output decodePkg::uopOpcode_e storeOp,
    output logic                  storeIllegal
);

    logic [2:0] funct3;

    assign funct3 = instr[14:12];

    always_comb begin
        loadIllegal = 1'b0;
        case (funct3)
            3'd0: loadOp = decodePkg::lsuLb;
            3'd1: loadOp = decodePkg::lsuLh;
            3'd2: loadOp = decodePkg::lsuLw;
            3'd4: loadOp = decodePkg::lsuLbu;
            3'd5: loadOp = decodePkg::lsuLhu;
            default: begin
                loadOp = decodePkg::intUndefined;
                loadIllegal = 1'b1;
            end
        endcase
    end

    // only byte, half and word stores exist in rv32
    always_comb begin
        storeIllegal = 1'b0;
        case (funct3)
            3'd0: storeOp = decodePkg::lsuSb;
            3'd1: storeOp = decodePkg::lsuSh;
            3'd2: storeOp = decodePkg::lsuSw;
            default: begin
                storeOp = decodePkg::intUndefined;
                storeIllegal = 1'b1;
            end
        endcase
    end

endmodule

//--- hdl/opcodeControl.sv
`timescale 1ns/1ps

module opcodeControl (
    input  decodePkg::word_t      instr,
    input  decodePkg::uopOpcode_e regImmOp,
    input  decodePkg::uopOpcode_e regRegOp,
    input  decodePkg::uopOpcode_e branchOp,
    input  decodePkg::uopOpcode_e loadOp,
    input  decodePkg::uopOpcode_e storeOp,
    input  decodePkg::funcUnit_e  regRegFu,
    input  logic                  regImmIllegal,
    input  logic                  regRegIllegal,
    input  logic                  branchIllegal,
    input  logic                  loadIllegal,
    input  logic                  storeIllegal,
    output decodePkg::immFormat_e immFmt,
    output decodePkg::funcUnit_e  fu,
    output decodePkg::uopOpcode_e opcode,
    output decodePkg::regAddr_t   rs0,
    output decodePkg::regAddr_t   rs1,
    output decodePkg::regAddr_t   rd,
    output logic                  pcA,
    output logic                  immB
);

    logic illegal;

    always_comb begin
        immFmt = decodePkg::immNone;
        fu = decodePkg::fuInt;
        opcode = decodePkg::intUndefined;
        rs0 = '0;
        rs1 = '0;
        rd = '0;
        pcA = 1'b0;
        immB = 1'b0;
        illegal = 1'b1;

        // 16-bit words never match and fall through as illegal
        if (instr[1:0] == decodePkg::quadrant32) begin
            case (instr[6:0])
                decodePkg::opcLui: begin
                    rd = instr[11:7];
                    immB = 1'b1;
                    immFmt = decodePkg::immU;
                    opcode = decodePkg::intLui;
                    illegal = 1'b0;
                end
                decodePkg::opcAuipc: begin
                    rd = instr[11:7];
                    pcA = 1'b1;
                    immB = 1'b1;
                    immFmt = decodePkg::immU;
                    opcode = decodePkg::intAuipc;
                    illegal = 1'b0;
                end
                decodePkg::opcJal: begin
                    rd = instr[11:7];
                    pcA = 1'b1;
                    immB = 1'b1;
                    immFmt = decodePkg::immJal;
                    opcode = decodePkg::intJal;
                    illegal = 1'b0;
                end
                decodePkg::opcJalr: begin
                    // base register goes out on rs1 so srcA can carry the pc
                    rs1 = instr[19:15];
                    rd = instr[11:7];
                    pcA = 1'b1;
                    immFmt = decodePkg::immI;
                    opcode = decodePkg::intJalr;
                    illegal = 1'b0;
                end
                decodePkg::opcLoad: begin
                    rs0 = instr[19:15];
                    rd = instr[11:7];
                    immB = 1'b1;
                    immFmt = decodePkg::immI;
                    fu = decodePkg::fuLsu;
                    opcode = loadOp;
                    illegal = loadIllegal;
                end
                decodePkg::opcStore: begin
                    rs0 = instr[19:15];
                    rs1 = instr[24:20];
                    immFmt = decodePkg::immS;
                    fu = decodePkg::fuLsu;
                    opcode = storeOp;
                    illegal = storeIllegal;
                end
                decodePkg::opcBranch: begin
                    rs0 = instr[19:15];
                    rs1 = instr[24:20];
                    immFmt = decodePkg::immBranch;
                    opcode = branchOp;
                    illegal = branchIllegal;
                end
                decodePkg::opcRegImm: begin
                    rs0 = instr[19:15];
                    rd = instr[11:7];
                    immB = 1'b1;
                    immFmt = decodePkg::immI;
                    opcode = regImmOp;
                    illegal = regImmIllegal;
                end
                decodePkg::opcRegReg: begin
                    rs0 = instr[19:15];
                    rs1 = instr[24:20];
                    rd = instr[11:7];
                    fu = regRegFu;
                    opcode = regRegOp;
                    illegal = regRegIllegal;
                end
                decodePkg::opcEnv: begin
                    pcA = 1'b1;
                    immB = 1'b1;
                    immFmt = decodePkg::immI;
                    opcode = decodePkg::intSys;
                    illegal = 1'b0;
                end
                default: ;
            endcase
        end

        if (illegal) begin
            opcode = decodePkg::intUndefined;
            fu = decodePkg::fuInt;
        end
    end

endmodule

//--- hdl/uopStage.sv
`timescale 1ns/1ps

module uopStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  en,
    input  logic                  inValid,
    input  decodePkg::word_t      pcByte,
    input  decodePkg::word_t      imm,
    input  decodePkg::funcUnit_e  fu,
    input  decodePkg::uopOpcode_e opcode,
    input  decodePkg::regAddr_t   rs0,
    input  decodePkg::regAddr_t   rs1,
    input  decodePkg::regAddr_t   rd,
    input  logic                  pcA,
    input  logic                  immB,
    output logic                  uopValid,
    output decodePkg::word_t      uopPc,
    output decodePkg::word_t      uopImm,
    output decodePkg::funcUnit_e  uopFu,
    output decodePkg::uopOpcode_e uopOpcode,
    output decodePkg::regAddr_t   uopRs0,
    output decodePkg::regAddr_t   uopRs1,
    output decodePkg::regAddr_t   uopRd,
    output logic                  uopPcA,
    output logic                  uopImmB
);

    always_ff @(posedge clk) begin
        if (reset) begin
            uopValid <= 1'b0;
            uopPc <= '0;
            uopImm <= '0;
            uopFu <= decodePkg::fuInt;
            uopOpcode <= decodePkg::uopOpcode_e'('0);
            uopRs0 <= '0;
            uopRs1 <= '0;
            uopRd <= '0;
            uopPcA <= 1'b0;
            uopImmB <= 1'b0;
        end else begin
            // a stall only drops valid, fields still follow the input
            uopValid <= inValid && en;
            uopPc <= pcByte;
            uopImm <= imm;
            uopFu <= fu;
            uopOpcode <= opcode;
            uopRs0 <= rs0;
            uopRs1 <= rs1;
            uopRd <= rd;
            uopPcA <= pcA;
            uopImmB <= immB;
        end
    end

endmodule

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder #(
    parameter int numUops = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         en,
    input  decodePkg::word_t             instr     [numUops-1:0],
    input  logic [decodePkg::pcWidth-1:0] pc       [numUops-1:0],
    input  logic                         inValid   [numUops-1:0],
    output logic                         uopValid  [numUops-1:0],
    output decodePkg::word_t             uopPc     [numUops-1:0],
    output decodePkg::word_t             uopImm    [numUops-1:0],
    output decodePkg::regAddr_t          uopRs0    [numUops-1:0],
    output decodePkg::regAddr_t          uopRs1    [numUops-1:0],
    output decodePkg::regAddr_t          uopRd     [numUops-1:0],
    output decodePkg::funcUnit_e         uopFu     [numUops-1:0],
    output decodePkg::uopOpcode_e        uopOpcode [numUops-1:0],
    output logic                         uopPcA    [numUops-1:0],
    output logic                         uopImmB   [numUops-1:0]
);

    for (genvar lane = 0; lane < numUops; lane++) begin : laneGen
        decodePkg::word_t pcByte;
        decodePkg::word_t imm;
        decodePkg::immFormat_e immFmt;
        decodePkg::funcUnit_e fu;
        decodePkg::funcUnit_e regRegFu;
        decodePkg::uopOpcode_e opcode;
        decodePkg::uopOpcode_e regImmOp;
        decodePkg::uopOpcode_e regRegOp;
        decodePkg::uopOpcode_e branchOp;
        decodePkg::uopOpcode_e loadOp;
        decodePkg::uopOpcode_e storeOp;
        decodePkg::regAddr_t rs0;
        decodePkg::regAddr_t rs1;
        decodePkg::regAddr_t rd;
        logic pcA;
        logic immB;
        logic regImmIllegal;
        logic regRegIllegal;
        logic branchIllegal;
        logic loadIllegal;
        logic storeIllegal;

        // pc arrives as a halfword address
        assign pcByte = {pc[lane], 1'b0};

        intOpDecode intOpDecode0 (
            .instr(instr[lane]),
            .regImmOp(regImmOp),
            .regImmIllegal(regImmIllegal),
            .regRegOp(regRegOp),
            .regRegFu(regRegFu),
            .regRegIllegal(regRegIllegal),
            .branchOp(branchOp),
            .branchIllegal(branchIllegal)
        );

        memOpDecode memOpDecode0 (
            .instr(instr[lane]),
            .loadOp(loadOp),
            .loadIllegal(loadIllegal),
            .storeOp(storeOp),
            .storeIllegal(storeIllegal)
        );

        opcodeControl opcodeControl0 (
            .instr(instr[lane]),
            .regImmOp(regImmOp),
            .regRegOp(regRegOp),
            .branchOp(branchOp),
            .loadOp(loadOp),
            .storeOp(storeOp),
            .regRegFu(regRegFu),
            .regImmIllegal(regImmIllegal),
            .regRegIllegal(regRegIllegal),
            .branchIllegal(branchIllegal),
            .loadIllegal(loadIllegal),
            .storeIllegal(storeIllegal),
            .immFmt(immFmt),
            .fu(fu),
            .opcode(opcode),
            .rs0(rs0),
            .rs1(rs1),
            .rd(rd),
            .pcA(pcA),
            .immB(immB)
        );

        immGen immGen0 (
            .instr(instr[lane]),
            .immFmt(immFmt),
            .pcByte(pcByte),
            .imm(imm)
        );

        uopStage uopStage0 (
            .clk(clk),
            .reset(reset),
            .en(en),
            .inValid(inValid[lane]),
            .pcByte(pcByte),
            .imm(imm),
            .fu(fu),
            .opcode(opcode),
            .rs0(rs0),
            .rs1(rs1),
            .rd(rd),
            .pcA(pcA),
            .immB(immB),
            .uopValid(uopValid[lane]),
            .uopPc(uopPc[lane]),
            .uopImm(uopImm[lane]),
            .uopFu(uopFu[lane]),
            .uopOpcode(uopOpcode[lane]),
            .uopRs0(uopRs0[lane]),
            .uopRs1(uopRs1[lane]),
            .uopRd(uopRd[lane]),
            .uopPcA(uopPcA[lane]),
            .uopImmB(uopImmB[lane])
        );
    end

endmodule

//--- test/clkGen.sv
`timescale 1ns/1ps

module clkGen #(
    parameter realtime halfPeriod = 5ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free-running, first rising edge at one half period
    always begin
        #(halfPeriod);
        clk = ~clk;
    end

endmodule

//--- test/instrDecoderTb.sv
`timescale 1ns/1ps

module instrDecoderTb;

    localparam int numLanes = 2;
    localparam int resetCycles = 10;
    localparam int edgeLimitNs = 53;

    typedef struct {
        decodePkg::word_t      instr;
        bit                    pcRel;
        bit                    inValid;
        bit                    en;
        decodePkg::funcUnit_e  fu;
        decodePkg::uopOpcode_e opcode;
        decodePkg::regAddr_t   rs0;
        decodePkg::regAddr_t   rs1;
        decodePkg::regAddr_t   rd;
        bit                    pcA;
        bit                    immB;
        decodePkg::word_t      imm;
    } row_t;

    logic                          clk;
    logic                          reset;
    logic                          en;
    decodePkg::word_t              instr     [numLanes-1:0];
    logic [decodePkg::pcWidth-1:0] pc        [numLanes-1:0];
    logic                          inValid   [numLanes-1:0];
    logic                          uopValid  [numLanes-1:0];
    decodePkg::word_t              uopPc     [numLanes-1:0];
    decodePkg::word_t              uopImm    [numLanes-1:0];
    decodePkg::regAddr_t           uopRs0    [numLanes-1:0];
    decodePkg::regAddr_t           uopRs1    [numLanes-1:0];
    decodePkg::regAddr_t           uopRd     [numLanes-1:0];
    decodePkg::funcUnit_e          uopFu     [numLanes-1:0];
    decodePkg::uopOpcode_e         uopOpcode [numLanes-1:0];
    logic                          uopPcA    [numLanes-1:0];
    logic                          uopImmB   [numLanes-1:0];

    int valueErrors;
    int timeoutErrors;
    row_t rows[$];
    // expected side of each lane for the cycle in flight
    int laneRow [numLanes];
    decodePkg::word_t lanePcByte [numLanes];
    bit enApplied;

    clkGen clkGen0 (.clk(clk));

    instrDecoder #(.numUops(numLanes)) dut0 (
        .clk(clk),
        .reset(reset),
        .en(en),
        .instr(instr),
        .pc(pc),
        .inValid(inValid),
        .uopValid(uopValid),
        .uopPc(uopPc),
        .uopImm(uopImm),
        .uopRs0(uopRs0),
        .uopRs1(uopRs1),
        .uopRd(uopRd),
        .uopFu(uopFu),
        .uopOpcode(uopOpcode),
        .uopPcA(uopPcA),
        .uopImmB(uopImmB)
    );

    function automatic row_t mk(decodePkg::word_t i, bit rel, bit v, bit e,
            decodePkg::funcUnit_e f, decodePkg::uopOpcode_e o, decodePkg::regAddr_t a,
            decodePkg::regAddr_t b, decodePkg::regAddr_t d, bit p, bit ib,
            decodePkg::word_t im);
        row_t r;
        r = '{i, rel, v, e, f, o, a, b, d, p, ib, im};
        return r;
    endfunction

    // pc-relative rows hold the offset and the target is formed per lane
    task automatic buildTable();
        rows.push_back(mk(32'h123452B7, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intLui, 5'd0, 5'd0, 5'd5, 1'b0, 1'b1, 32'h12345000));
        rows.push_back(mk(32'hFFFFF397, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intAuipc, 5'd0, 5'd0, 5'd7, 1'b1, 1'b1, 32'hFFFFF000));
        rows.push_back(mk(32'h008000EF, 1'b1, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intJal, 5'd0, 5'd0, 5'd1, 1'b1, 1'b1, 32'h00000008));
        rows.push_back(mk(32'hFFDFF06F, 1'b1, 1'b1, 1'b0, decodePkg::fuInt,
            decodePkg::intJal, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 32'hFFFFFFFC));
        rows.push_back(mk(32'h004100E7, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intJalr, 5'd0, 5'd2, 5'd1, 1'b1, 1'b0, 32'h00000004));
        rows.push_back(mk(32'hFF822183, 1'b0, 1'b0, 1'b1, decodePkg::fuLsu,
            decodePkg::lsuLw, 5'd4, 5'd0, 5'd3, 1'b0, 1'b1, 32'hFFFFFFF8));
        rows.push_back(mk(32'h0013C303, 1'b0, 1'b1, 1'b1, decodePkg::fuLsu,
            decodePkg::lsuLbu, 5'd7, 5'd0, 5'd6, 1'b0, 1'b1, 32'h00000001));
        rows.push_back(mk(32'h00952623, 1'b0, 1'b1, 1'b1, decodePkg::fuLsu,
            decodePkg::lsuSw, 5'd10, 5'd9, 5'd0, 1'b0, 1'b0, 32'h0000000C));
        rows.push_back(mk(32'hFE110FA3, 1'b0, 1'b0, 1'b0, decodePkg::fuLsu,
            decodePkg::lsuSb, 5'd2, 5'd1, 5'd0, 1'b0, 1'b0, 32'hFFFFFFFF));
        rows.push_back(mk(32'h00208863, 1'b1, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intBeq, 5'd1, 5'd2, 5'd0, 1'b0, 1'b0, 32'h00000010));
        rows.push_back(mk(32'hFE41FCE3, 1'b1, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intBgeu, 5'd3, 5'd4, 5'd0, 1'b0, 1'b0, 32'hFFFFFFF8));
        rows.push_back(mk(32'hFFF30293, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intAdd, 5'd6, 5'd0, 5'd5, 1'b0, 1'b1, 32'hFFFFFFFF));
        rows.push_back(mk(32'h40315093, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intSra, 5'd2, 5'd0, 5'd1, 1'b0, 1'b1, 32'h00000403));
        rows.push_back(mk(32'h405201B3, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intSub, 5'd4, 5'd5, 5'd3, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h003170B3, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intAnd, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h00000073, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intSys, 5'd0, 5'd0, 5'd0, 1'b1, 1'b1, 32'h0));
        // rv32m rows walk funct3 from 0 to 7
        rows.push_back(mk(32'h023100B3, 1'b0, 1'b1, 1'b1, decodePkg::fuMul,
            decodePkg::mulMul, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023110B3, 1'b0, 1'b1, 1'b1, decodePkg::fuMul,
            decodePkg::mulMulh, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023120B3, 1'b0, 1'b1, 1'b1, decodePkg::fuMul,
            decodePkg::mulMulsu, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023130B3, 1'b0, 1'b1, 1'b1, decodePkg::fuMul,
            decodePkg::mulMulu, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023140B3, 1'b0, 1'b1, 1'b1, decodePkg::fuDiv,
            decodePkg::divDiv, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023150B3, 1'b0, 1'b1, 1'b1, decodePkg::fuDiv,
            decodePkg::divDivu, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023160B3, 1'b0, 1'b1, 1'b1, decodePkg::fuDiv,
            decodePkg::divRem, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h023170B3, 1'b0, 1'b1, 1'b1, decodePkg::fuDiv,
            decodePkg::divRemu, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        // illegal encodings keep their register and immediate fields
        rows.push_back(mk(32'hFF823183, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd4, 5'd0, 5'd3, 1'b0, 1'b1, 32'hFFFFFFF8));
        rows.push_back(mk(32'h00954623, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd10, 5'd9, 5'd0, 1'b0, 1'b0, 32'h0000000C));
        rows.push_back(mk(32'h0020A863, 1'b1, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd1, 5'd2, 5'd0, 1'b0, 1'b0, 32'h00000010));
        rows.push_back(mk(32'hFE3100B3, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h40311093, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd2, 5'd0, 5'd1, 1'b0, 1'b1, 32'h00000403));
        rows.push_back(mk(32'h1234507F, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'h0));
        rows.push_back(mk(32'h00004501, 1'b0, 1'b1, 1'b1, decodePkg::fuInt,
            decodePkg::intUndefined, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 32'h0));
    endtask

    task automatic checkOpcode(input decodePkg::uopOpcode_e got,
            input decodePkg::uopOpcode_e exp, input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic checkFu(input decodePkg::funcUnit_e got,
            input decodePkg::funcUnit_e exp, input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic checkWord(input decodePkg::word_t got, input decodePkg::word_t exp,
            input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkReg(input decodePkg::regAddr_t got, input decodePkg::regAddr_t exp,
            input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: %s got x%0d expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic waitFalling();
        bit timedOut;
        timedOut = 1'b1;
        fork
            begin
                // wait out a high phase so the step from x at time zero is no edge
                wait (clk === 1'b1);
                @(negedge clk);
                timedOut = 1'b0;
            end
            #(edgeLimitNs);
        join_any
        disable fork;
        if (timedOut) begin
            timeoutErrors++;
            $display("Timeout: no falling clock edge seen within %0d ns", edgeLimitNs);
        end
    endtask

    task automatic applyRow(input int lane, input int idx, input logic [30:0] pcVal);
        instr[lane] = rows[idx].instr;
        pc[lane] = pcVal;
        inValid[lane] = rows[idx].inValid;
        laneRow[lane] = idx;
        lanePcByte[lane] = {pcVal, 1'b0};
    endtask

    task automatic checkLane(input int lane);
        row_t r;
        decodePkg::word_t expImm;
        string tag;
        r = rows[laneRow[lane]];
        tag = $sformatf("lane %0d row %0d", lane, laneRow[lane]);
        expImm = r.pcRel ? lanePcByte[lane] + r.imm : r.imm;
        checkFlag(uopValid[lane], r.inValid && enApplied, {tag, " valid"});
        checkWord(uopPc[lane], lanePcByte[lane], {tag, " pc"});
        checkWord(uopImm[lane], expImm, {tag, " imm"});
        checkFu(uopFu[lane], r.fu, {tag, " fu"});
        checkOpcode(uopOpcode[lane], r.opcode, {tag, " opcode"});
        checkReg(uopRs0[lane], r.rs0, {tag, " rs0"});
        checkReg(uopRs1[lane], r.rs1, {tag, " rs1"});
        checkReg(uopRd[lane], r.rd, {tag, " rd"});
        checkFlag(uopPcA[lane], r.pcA, {tag, " pcA"});
        checkFlag(uopImmB[lane], r.immB, {tag, " immB"});
    endtask

    initial begin
        decodePkg::word_t seedDummy;
        decodePkg::word_t rnd;
        seedDummy = $urandom(32'hb1fc_6b63);
        valueErrors = 0;
        timeoutErrors = 0;
        enApplied = 1'b0;
        // valid and enable high so only reset can hold the outputs low
        reset = 1'b1;
        en = 1'b1;
        for (int l = 0; l < numLanes; l++) begin
            instr[l] = '0;
            pc[l] = '0;
            inValid[l] = 1'b1;
        end
        buildTable();

        for (int c = 0; c < resetCycles && timeoutErrors == 0; c++) begin
            waitFalling();
            for (int l = 0; l < numLanes; l++) begin
                checkFlag(uopValid[l], 1'b0, $sformatf("lane %0d valid in reset", l));
            end
        end
        reset = 1'b0;
        en = 1'b0;
        waitFalling();
        for (int l = 0; l < numLanes; l++) begin
            checkFlag(uopValid[l], 1'b0, $sformatf("lane %0d valid after reset", l));
        end

        // lane 1 runs one row ahead of lane 0
        for (int i = 0; i < rows.size() && timeoutErrors == 0; i++) begin
            en = rows[i].en;
            enApplied = rows[i].en;
            for (int l = 0; l < numLanes; l++) begin
                rnd = $urandom;
                applyRow(l, (i + l) % rows.size(), rnd[30:0]);
            end
            waitFalling();
            if (timeoutErrors == 0) begin
                for (int l = 0; l < numLanes; l++) begin
                    checkLane(l);
                end
            end
        end

        $display("Summary: %0d value errors, %0d timeouts", valueErrors, timeoutErrors);
        if (valueErrors == 0 && timeoutErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/decodePkg.sv
hdl/immGen.sv
hdl/intOpDecode.sv
hdl/memOpDecode.sv
hdl/opcodeControl.sv
hdl/uopStage.sv
hdl/instrDecoder.sv
test/clkGen.sv
test/instrDecoderTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= instrDecoderTb
FLIST     ?= vlog.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
